/* src/ea_mode_pkg.sv */
package ea_mode_pkg;

    typedef enum logic [2:0] {
        short_reg,     // 0x00-0x3f style, bit 6 clear
        absolute,      // (#8) (#16) (#24)
        reg_indirect,  // (r32) (r32+d16) (r32+r8/r16)
        reg_autostep,  // (-r32) (r32+)
        none
    } ea_class_t;

    typedef enum logic {
        phase_first,  // mode byte and register byte
        phase_ext     // d16 word or base/offset selector pair
    } ea_phase_t;

    typedef enum logic [1:0] {
        step_1 = 2'd0,
        step_2 = 2'd1,
        step_4 = 2'd2
    } step_code_t;

    // mode byte codes as {b[6], b[3:0]}
    localparam logic [4:0] mode_abs8    = 5'h10;
    localparam logic [4:0] mode_abs16   = 5'h11;
    localparam logic [4:0] mode_abs24   = 5'h12;
    localparam logic [4:0] mode_rind    = 5'h13;
    localparam logic [4:0] mode_predec  = 5'h14;
    localparam logic [4:0] mode_postinc = 5'h15;

    function automatic ea_class_t classify(input logic [7:0] mb);
        logic [4:0] m;
        m = {mb[6], mb[3:0]};
        if (!m[4]) return short_reg;
        case (m)
            mode_abs8, mode_abs16, mode_abs24: return absolute;
            mode_rind:                         return reg_indirect;
            mode_predec, mode_postinc:         return reg_autostep;
            default:                           return none;
        endcase
    endfunction

    function automatic step_code_t step_decode(input logic [1:0] code);
        case (code)
            2'd0:    return step_1;
            2'd1:    return step_2;
            default: return step_4;  // 2'd3 is reserved
        endcase
    endfunction

    function automatic logic [2:0] step_size(input step_code_t code);
        case (code)
            step_1:  return 3'd1;
            step_2:  return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

endpackage

/* src/reg_map_pkg.sv */
package reg_map_pkg;

    localparam int reg_sel_w = 8;
    localparam int data_w    = 32;
    localparam int addr_w    = 24;
    localparam int num_regs  = 8;
    localparam int reg_idx_w = $clog2(num_regs);

    // XWA e0, XBC e4, XDE e8, XHL ec, XIX f0, XIY f4, XIZ f8, XSP fc
    localparam logic [reg_sel_w-1:0] full_reg_base = 8'he0;
    localparam logic [reg_sel_w-1:0] null_sel      = 8'h40;  // outside the bank, reads 0

    // 3-bit register code to full-register selector
    function automatic logic [reg_sel_w-1:0] full_sel(input logic [reg_idx_w-1:0] code);
        return full_reg_base + {code, 2'b00};
    endfunction

endpackage

/* src/op_window.sv */
`timescale 1ns/10ps

module op_window #(
    parameter int win_depth = 8
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cen,
    input  logic                            code_wr,
    input  logic [7:0]                      code_byte,
    input  logic [2:0]                      fetched,
    output logic [31:0]                     op,
    output logic                            op_valid,
    output logic [$clog2(win_depth+1)-1:0]  win_count
);

    // depth must be a power of two, pointers wrap on their own
    localparam int ptr_w = $clog2(win_depth);
    localparam int cnt_w = $clog2(win_depth+1);

    logic [7:0]       mem [win_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic [cnt_w-1:0] pop_n;
    logic             push;

    assign push      = cen && code_wr && count != cnt_w'(win_depth);  // full drops the byte
    assign op_valid  = count >= cnt_w'(4);
    assign win_count = count;

    always_comb begin
        pop_n = cnt_w'(fetched);
        if (pop_n > count) begin
            pop_n = count;  // never pop past the write pointer
        end
    end

    // oldest byte lands in op[7:0]
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            op[8*i +: 8] = mem[rd_ptr + ptr_w'(i)];
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= code_byte;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (cen) begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            rd_ptr <= rd_ptr + ptr_w'(pop_n);
            count  <= count + cnt_w'(push) - pop_n;  // write and consume may overlap
        end
    end

endmodule

/* src/ea_decode.sv */
`timescale 1ns/10ps

module ea_decode (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cen,
    input  logic                              ea_req,
    input  logic [31:0]                       op,
    input  logic                              op_valid,
    output logic [2:0]                        fetched,
    output logic [reg_map_pkg::reg_sel_w-1:0] rd_sel,
    output logic [reg_map_pkg::reg_sel_w-1:0] aux_sel,
    input  logic [reg_map_pkg::data_w-1:0]    rd_data,
    input  logic [15:0]                       aux_data,
    output ea_mode_pkg::step_code_t           reg_step,
    output logic                              step_inc,
    output logic                              step_dec,
    output logic                              ea_done,
    output logic [reg_map_pkg::addr_w-1:0]    ea_addr
);
    import ea_mode_pkg::*;
    import reg_map_pkg::*;

    ea_phase_t            phase;
    ea_phase_t            nx_phase;
    ea_class_t            op_class;
    step_code_t           nx_step;
    logic                 pre_done;
    logic                 nx_pre_done;
    logic                 pre_inc;
    logic                 nx_pre_inc;
    logic                 nx_dec;
    logic                 use_aux;
    logic                 nx_use_aux;
    logic                 aux_wide;
    logic                 nx_aux_wide;
    logic [reg_sel_w-1:0] nx_rd_sel;
    logic [reg_sel_w-1:0] nx_aux_sel;
    logic [addr_w-1:0]    offset;
    logic [addr_w-1:0]    nx_offset;
    logic [addr_w-1:0]    aux_ext;
    logic [addr_w-1:0]    nx_addr;
    logic                 start;
    logic                 in_ext;

    assign op_class = classify(op[7:0]);
    assign start    = ea_req && !pre_done && phase == phase_first && op_valid;
    assign in_ext   = ea_req && !pre_done && phase == phase_ext;

    // base plus offset, or base plus the signed offset register
    always_comb begin
        aux_ext = aux_wide ? {{(addr_w-16){aux_data[15]}}, aux_data}
                           : {{(addr_w-8){aux_data[7]}}, aux_data[7:0]};
        nx_addr = rd_data[addr_w-1:0] + (use_aux ? aux_ext : offset);
    end

    always_comb begin
        fetched     = 3'd0;
        nx_phase    = phase_first;
        nx_pre_done = pre_done && ea_req;  // held until the request drops
        nx_pre_inc  = 1'b0;
        nx_dec      = 1'b0;
        nx_step     = reg_step;
        nx_rd_sel   = rd_sel;
        nx_aux_sel  = aux_sel;
        nx_offset   = offset;
        nx_use_aux  = use_aux;
        nx_aux_wide = aux_wide;
        if (start) begin
            nx_use_aux = 1'b0;
            case (op_class)
                short_reg: begin
                    nx_rd_sel   = full_sel(op[2:0]);
                    nx_offset   = op[3] ? {{(addr_w-8){op[15]}}, op[15:8]} : '0;
                    fetched     = op[3] ? 3'd2 : 3'd1;  // bit 3 adds a d8 byte
                    nx_pre_done = 1'b1;
                end
                absolute: begin
                    nx_rd_sel   = null_sel;
                    nx_pre_done = 1'b1;
                    case (op[1:0])
                        2'd0: begin
                            nx_offset = addr_w'(op[15:8]);
                            fetched   = 3'd2;
                        end
                        2'd1: begin
                            nx_offset = addr_w'(op[23:8]);
                            fetched   = 3'd3;
                        end
                        default: begin
                            nx_offset = addr_w'(op[31:8]);
                            fetched   = 3'd4;
                        end
                    endcase
                end
                reg_indirect: begin
                    nx_rd_sel = {op[15:10], 2'b00};
                    nx_offset = '0;
                    fetched   = 3'd2;
                    case (op[9:8])
                        2'd1: nx_phase = phase_ext;  // d16 follows
                        2'd3: begin
                            nx_phase    = phase_ext;  // base and offset selectors follow
                            nx_use_aux  = 1'b1;
                            nx_aux_wide = op[10];
                        end
                        default: nx_pre_done = 1'b1;  // plain (r32)
                    endcase
                end
                reg_autostep: begin
                    nx_rd_sel   = {op[15:10], 2'b00};
                    nx_step     = step_decode(op[9:8]);
                    fetched     = 3'd2;
                    nx_pre_done = 1'b1;
                    if (!op[0]) begin
                        // bank is still old here, so subtract the step ourselves
                        nx_dec    = 1'b1;
                        nx_offset = '0 - addr_w'(step_size(step_decode(op[9:8])));
                    end else begin
                        nx_pre_inc = 1'b1;
                        nx_offset  = '0;
                    end
                end
                default: begin
                    nx_rd_sel   = null_sel;  // unknown mode, skip the byte
                    nx_offset   = '0;
                    fetched     = 3'd1;
                    nx_pre_done = 1'b1;
                end
            endcase
        end else if (in_ext) begin
            fetched     = 3'd2;
            nx_pre_done = 1'b1;
            if (use_aux) begin
                nx_rd_sel  = {op[7:2], 2'b00};
                nx_aux_sel = op[15:8];
            end else begin
                nx_offset = {{(addr_w-16){op[15]}}, op[15:0]};
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase    <= phase_first;
            pre_done <= 1'b0;
            ea_done  <= 1'b0;
            pre_inc  <= 1'b0;
            step_inc <= 1'b0;
            step_dec <= 1'b0;
            use_aux  <= 1'b0;
            aux_wide <= 1'b0;
            reg_step <= step_1;
            rd_sel   <= null_sel;
            aux_sel  <= null_sel;
        end else if (cen) begin
            phase    <= nx_phase;
            pre_done <= nx_pre_done;
            ea_done  <= pre_done && ea_req;
            pre_inc  <= nx_pre_inc;
            step_inc <= pre_inc;  // post-increment lands after the address is taken
            step_dec <= nx_dec;
            use_aux  <= nx_use_aux;
            aux_wide <= nx_aux_wide;
            reg_step <= nx_step;
            rd_sel   <= nx_rd_sel;
            aux_sel  <= nx_aux_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            offset <= nx_offset;
            if (ea_req && !ea_done) begin
                ea_addr <= nx_addr;  // frozen once done
            end
        end
    end

endmodule

/* src/reg_bank.sv */
`timescale 1ns/10ps

module reg_bank (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              wr,
    input  logic [reg_map_pkg::reg_sel_w-1:0] wr_sel,
    input  logic [reg_map_pkg::data_w-1:0]    wr_data,
    input  logic [reg_map_pkg::reg_sel_w-1:0] rd_sel,
    input  logic [reg_map_pkg::reg_sel_w-1:0] aux_sel,
    output logic [reg_map_pkg::data_w-1:0]    rd_data,
    output logic [15:0]                       aux_data,
    input  ea_mode_pkg::step_code_t           reg_step,
    input  logic                              step_inc,
    input  logic                              step_dec
);
    import ea_mode_pkg::*;
    import reg_map_pkg::*;

    logic [data_w-1:0]    regs [num_regs];
    logic [data_w-1:0]    aux_word;
    logic [data_w-1:0]    step_amt;
    logic [reg_idx_w-1:0] wr_idx;
    logic [reg_idx_w-1:0] step_idx;
    logic                 wr_hit;
    logic                 step_hit;

    function automatic logic in_bank(input logic [reg_sel_w-1:0] sel);
        return sel[reg_sel_w-1:reg_idx_w+2] == full_reg_base[reg_sel_w-1:reg_idx_w+2];
    endfunction

    function automatic logic [reg_idx_w-1:0] sel_idx(input logic [reg_sel_w-1:0] sel);
        return sel[reg_idx_w+1:2];
    endfunction

    // low selector bits pick the starting byte
    function automatic logic [data_w-1:0] sel_read(input logic [reg_sel_w-1:0] sel,
                                                   input logic [data_w-1:0]    word);
        if (!in_bank(sel)) return '0;  // null_sel and unmapped codes
        return word >> {sel[1:0], 3'b000};
    endfunction

    assign rd_data  = sel_read(rd_sel, regs[sel_idx(rd_sel)]);
    assign aux_word = sel_read(aux_sel, regs[sel_idx(aux_sel)]);
    assign aux_data = aux_word[15:0];

    assign wr_hit   = in_bank(wr_sel);
    assign wr_idx   = sel_idx(wr_sel);
    assign step_hit = in_bank(rd_sel);  // steps act on the register being read
    assign step_idx = sel_idx(rd_sel);
    assign step_amt = data_w'(step_size(reg_step));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (step_hit && step_inc) begin
                regs[step_idx] <= regs[step_idx] + step_amt;
            end else if (step_hit && step_dec) begin
                regs[step_idx] <= regs[step_idx] - step_amt;
            end
            if (wr && wr_hit) begin
                regs[wr_idx] <= wr_data;  // external write beats a step
            end
        end
    end

endmodule

/* src/ea_unit.sv */
`timescale 1ns/10ps

module ea_unit #(
    parameter int win_depth = 8
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cen,
    input  logic                              code_wr,
    input  logic [7:0]                        code_byte,
    input  logic                              ea_req,
    input  logic                              reg_wr,
    input  logic [reg_map_pkg::reg_sel_w-1:0] reg_wr_sel,
    input  logic [reg_map_pkg::data_w-1:0]    reg_wr_data,
    output logic                              ea_done,
    output logic [reg_map_pkg::addr_w-1:0]    ea_addr,
    output logic [$clog2(win_depth+1)-1:0]    win_count
);
    import ea_mode_pkg::*;
    import reg_map_pkg::*;

    logic [31:0]          op;
    logic                 op_valid;
    logic [2:0]           fetched;
    logic [reg_sel_w-1:0] rd_sel;
    logic [reg_sel_w-1:0] aux_sel;
    logic [data_w-1:0]    rd_data;
    logic [15:0]          aux_data;
    step_code_t           reg_step;
    logic                 step_inc;
    logic                 step_dec;

    op_window #(
        .win_depth (win_depth)
    ) i_window (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .code_wr   (code_wr),
        .code_byte (code_byte),
        .fetched   (fetched),
        .op        (op),
        .op_valid  (op_valid),
        .win_count (win_count)
    );

    ea_decode i_decode (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .ea_req   (ea_req),
        .op       (op),
        .op_valid (op_valid),
        .fetched  (fetched),
        .rd_sel   (rd_sel),
        .aux_sel  (aux_sel),
        .rd_data  (rd_data),
        .aux_data (aux_data),
        .reg_step (reg_step),
        .step_inc (step_inc),
        .step_dec (step_dec),
        .ea_done  (ea_done),
        .ea_addr  (ea_addr)
    );

    reg_bank i_bank (
        .clk      (clk),
        .rst      (rst),
        .wr       (reg_wr),
        .wr_sel   (reg_wr_sel),
        .wr_data  (reg_wr_data),
        .rd_sel   (rd_sel),
        .aux_sel  (aux_sel),
        .rd_data  (rd_data),
        .aux_data (aux_data),
        .reg_step (reg_step),
        .step_inc (step_inc),
        .step_dec (step_dec)
    );

endmodule

/* tests/ea_unit_tb.sv */
`timescale 1ns/10ps

module ea_unit_tb;
    import reg_map_pkg::*;

    localparam int  win_depth  = 8;
    localparam real clk_period = 4.0;
    localparam int  rand_ops   = 64;
    localparam int  num_ops    = 6 + 16 + 12 + 12 + rand_ops;

    logic                           clk;
    logic                           rst;
    logic                           cen;
    logic                           code_wr;
    logic [7:0]                     code_byte;
    logic                           ea_req;
    logic                           reg_wr;
    logic [reg_sel_w-1:0]           reg_wr_sel;
    logic [data_w-1:0]              reg_wr_data;
    logic                           ea_done;
    logic [addr_w-1:0]              ea_addr;
    logic [$clog2(win_depth+1)-1:0] win_count;

    logic [data_w-1:0] model_regs [num_regs];
    logic [7:0]        pending [$];  // operand bytes not yet pushed
    int                exp_len [$];
    int                exp_lat [$];
    logic [addr_w-1:0] exp_addr [$];
    int                q_count;      // bytes held in the DUT queue
    int                value_errors;
    int                timing_errors;
    integer            seed;

    ea_unit #(
        .win_depth (win_depth)
    ) i_dut (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .code_wr     (code_wr),
        .code_byte   (code_byte),
        .ea_req      (ea_req),
        .reg_wr      (reg_wr),
        .reg_wr_sel  (reg_wr_sel),
        .reg_wr_data (reg_wr_data),
        .ea_done     (ea_done),
        .ea_addr     (ea_addr),
        .win_count   (win_count)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2.0) clk = ~clk;
    end

    task automatic value_error(input string what);
        value_errors++;
        $display("mismatch at %0t: %s", $time, what);
    endtask

    task automatic timing_error(input string what);
        timing_errors++;
        $display("timing error at %0t: %s", $time, what);
    endtask

    done_high_at_drop: assert property (@(posedge clk) disable iff (rst)
        $fell(ea_req) |-> ea_done)
        else timing_error("ea_done was already low when ea_req fell");

    done_low_after_drop: assert property (@(posedge clk) disable iff (rst)
        !ea_req |=> !ea_done)
        else timing_error("ea_done still high one cycle after ea_req was low");

    addr_stable_while_done: assert property (@(posedge clk) disable iff (rst)
        ea_done |=> !ea_done || $stable(ea_addr))
        else timing_error("ea_addr changed while ea_done was high");

    function automatic logic [addr_w-1:0] sext8(input logic [7:0] v);
        return {{(addr_w-8){v[7]}}, v};
    endfunction

    function automatic logic [addr_w-1:0] sext16(input logic [15:0] v);
        return {{(addr_w-16){v[15]}}, v};
    endfunction

    function automatic logic [7:0] reg_selector(input int r);
        return full_reg_base + 8'(r * 4);  // XWA..XSP, 4 apart
    endfunction

    // r16 offsets start on a word boundary, r8 on any byte
    function automatic logic [7:0] aux_selector(input logic [31:0] v, input logic wide);
        logic [7:0] sel;
        sel = reg_selector(int'(v[18:16]));
        sel[1:0] = wide ? {v[20], 1'b0} : v[21:20];
        return sel;
    endfunction

    task automatic queue_op(input int len, input int lat, input logic [addr_w-1:0] addr);
        exp_len.push_back(len);
        exp_lat.push_back(lat);
        exp_addr.push_back(addr);
    endtask

    task automatic add_abs(input int kind, input logic [23:0] a);
        pending.push_back(8'h40 + 8'(kind));
        pending.push_back(a[7:0]);
        case (kind)
            0: queue_op(2, 2, {16'h0000, a[7:0]});
            1: begin
                pending.push_back(a[15:8]);
                queue_op(3, 2, {8'h00, a[15:0]});
            end
            default: begin
                pending.push_back(a[15:8]);
                pending.push_back(a[23:16]);
                queue_op(4, 2, a);
            end
        endcase
    endtask

    task automatic add_short(input int r, input logic with_d, input logic [7:0] d);
        pending.push_back({4'b0000, with_d, 3'(r)});
        if (with_d) begin
            pending.push_back(d);
            queue_op(2, 2, model_regs[r][addr_w-1:0] + sext8(d));
        end else begin
            queue_op(1, 2, model_regs[r][addr_w-1:0]);
        end
    endtask

    task automatic add_rind(input int r);
        pending.push_back(8'h43);
        pending.push_back(reg_selector(r));
        queue_op(2, 2, model_regs[r][addr_w-1:0]);
    endtask

    task automatic add_d16(input int r, input logic [15:0] d);
        pending.push_back(8'h43);
        pending.push_back(reg_selector(r) | 8'h01);
        pending.push_back(d[7:0]);
        pending.push_back(d[15:8]);
        queue_op(4, 3, model_regs[r][addr_w-1:0] + sext16(d));
    endtask

    task automatic add_reg_offset(input int r, input logic wide, input logic [7:0] asel);
        logic [data_w-1:0] aux;
        logic [addr_w-1:0] off;
        aux = model_regs[asel[4:2]] >> (8 * asel[1:0]);  // byte-aligned view
        off = wide ? sext16(aux[15:0]) : sext8(aux[7:0]);
        pending.push_back(8'h43);
        pending.push_back(wide ? 8'h07 : 8'h03);
        pending.push_back(reg_selector(r));
        pending.push_back(asel);
        queue_op(4, 3, model_regs[r][addr_w-1:0] + off);
    endtask

    task automatic add_step(input int r, input logic inc, input logic [1:0] sc);
        logic [data_w-1:0] size;
        size = data_w'(1) << sc;
        pending.push_back(inc ? 8'h45 : 8'h44);
        pending.push_back(reg_selector(r) | {6'b000000, sc});
        if (inc) begin
            queue_op(2, 2, model_regs[r][addr_w-1:0]);  // old value, then step
            model_regs[r] = model_regs[r] + size;
        end else begin
            model_regs[r] = model_regs[r] - size;
            queue_op(2, 2, model_regs[r][addr_w-1:0]);
        end
    endtask

    task automatic add_random_op();
        int          kind;
        int          r;
        logic [31:0] v;
        kind = $unsigned($random(seed)) % 7;
        r    = $unsigned($random(seed)) % 8;
        v    = $random(seed);
        case (kind)
            0: add_abs(int'(v[29:28] == 2'd3 ? 2'd2 : v[29:28]), v[23:0]);
            1: add_short(r, v[31], v[7:0]);
            2: add_rind(r);
            3: add_d16(r, v[15:0]);
            4: add_reg_offset(r, 1'b0, aux_selector(v, 1'b0));
            5: add_reg_offset(r, 1'b1, aux_selector(v, 1'b1));
            default: add_step(r, v[31], v[9:8] == 2'd3 ? 2'd2 : v[9:8]);
        endcase
    endtask

    task automatic preload_regs();
        logic [31:0] v;
        for (int i = 0; i < num_regs; i++) begin
            v = $random(seed);
            @(posedge clk);
            reg_wr      <= 1'b1;
            reg_wr_sel  <= reg_selector(i);
            reg_wr_data <= v;
            model_regs[i] = v;
        end
        @(posedge clk);
        reg_wr <= 1'b0;
    endtask

    task automatic release_reset();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        q_count = 0;
        pending.delete();
        for (int i = 0; i < num_regs; i++) begin
            model_regs[i] = '0;
        end
        assert (!ea_done) else value_error("ea_done high after reset");
        assert (win_count == '0)
            else value_error($sformatf("win_count %0d after reset", win_count));
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        release_reset();
    endtask

    // feed bytes, request, wait for done and release
    task automatic run_ops();
        int                len;
        int                lat;
        int                cycles;
        logic [7:0]        b;
        logic [addr_w-1:0] addr;
        while (exp_len.size() > 0) begin
            len  = exp_len.pop_front();
            lat  = exp_lat.pop_front();
            addr = exp_addr.pop_front();
            while (q_count < 4) begin
                b = 8'h00;  // filler past the last operand
                if (pending.size() > 0) begin
                    b = pending.pop_front();
                end
                @(posedge clk);
                code_wr   <= 1'b1;
                code_byte <= b;
                q_count++;
            end
            @(posedge clk);
            code_wr <= 1'b0;
            ea_req  <= 1'b1;
            cycles = 0;
            @(negedge clk);
            while (!ea_done) begin
                @(negedge clk);
                cycles++;
            end
            q_count -= len;
            assert (cycles == lat)
                else timing_error($sformatf("ea_done came %0d cycles after start, not %0d",
                                            cycles, lat));
            assert (ea_addr == addr)
                else value_error($sformatf("ea_addr %h, expected %h", ea_addr, addr));
            assert (int'(win_count) == q_count)
                else value_error($sformatf("win_count %0d, expected %0d", win_count, q_count));
            @(posedge clk);
            ea_req <= 1'b0;
            repeat (2) @(negedge clk);
            assert (!ea_done) else timing_error("ea_done did not fall after ea_req dropped");
            assert (ea_addr == addr)
                else value_error($sformatf("ea_addr %h not held, expected %h", ea_addr, addr));
        end
    endtask

    initial begin
        #(clk_period * 40.0 * num_ops);
        $display("timeout: the run did not finish within %0d operand slots", num_ops);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        logic [31:0] v;
        seed          = 32'h7130;
        rst           = 1'b1;
        cen           = 1'b1;
        code_wr       = 1'b0;
        code_byte     = 8'h00;
        ea_req        = 1'b0;
        reg_wr        = 1'b0;
        reg_wr_sel    = null_sel;
        reg_wr_data   = '0;
        value_errors  = 0;
        timing_errors = 0;
        q_count       = 0;
        release_reset();

        for (int k = 0; k < 3; k++) begin  // #8, #16, #24
            repeat (2) begin
                v = $random(seed);
                add_abs(k, v[23:0]);
            end
        end
        run_ops();

        apply_reset();
        preload_regs();
        for (int r = 0; r < num_regs; r++) begin
            v = $random(seed);
            add_short(r, 1'b0, 8'h00);
            add_short(r, 1'b1, v[7:0]);
        end
        run_ops();

        apply_reset();
        preload_regs();
        for (int i = 0; i < 3; i++) begin
            v = $random(seed);
            add_rind(int'(v[26:24]));
            add_d16(int'(v[26:24]), v[15:0]);
            add_reg_offset(int'(v[26:24]), 1'b0, aux_selector(v, 1'b0));
            add_reg_offset(int'(v[26:24]), 1'b1, aux_selector(v, 1'b1));
        end
        run_ops();

        apply_reset();
        preload_regs();
        for (int sc = 0; sc < 3; sc++) begin
            for (int dir = 0; dir < 2; dir++) begin
                v = $random(seed);
                add_step(int'(v[2:0]), dir[0], 2'(sc));
                add_rind(int'(v[2:0]));  // shows the stepped register
            end
        end
        run_ops();

        apply_reset();
        preload_regs();
        repeat (rand_ops) begin
            add_random_op();
        end
        run_ops();

        $display("checks done: %0d value errors, %0d timing errors", value_errors, timing_errors);
        if (value_errors == 0 && timing_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* ea_unit.f */
src/ea_mode_pkg.sv
src/reg_map_pkg.sv
src/op_window.sv
src/ea_decode.sv
src/reg_bank.sv
src/ea_unit.sv
tests/ea_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal -f ea_unit.f --top-module ea_unit_tb -o ea_unit_sim \
    && ./obj_dir/ea_unit_sim | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
